// File: Makefile
VERILATOR   ?= verilator
TOP         ?= memSysTb
DUT_TOP     ?= memSysTop
FLIST       ?= src.f
OBJ_DIR     ?= obj_dir
BUILD_FLAGS ?= --binary --timing -j 0 -Wno-fatal
LINT_FLAGS  ?= --lint-only --timing -Wall
PASS_TEXT   ?= >>> PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_TEXT)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(DUT_TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

// File: busArbiter.sv
// Three master bus arbiter
`timescale 1ns/10ps

module busArbiter (
  input  logic        clk,
  input  logic        rst,
  input  logic        walkRequest,
  input  logic [31:0] walkAddr,
  input  logic        walkWrite,
  input  logic [31:0] walkWData,
  input  logic        dRequest,
  input  logic [31:0] dAddr,
  input  logic        dWrite,
  input  logic [31:0] dWData,
  input  logic        iRequest,
  input  logic [31:0] iAddr,
  output logic        walkReady,
  output logic        dReady,
  output logic        iReady,
  output logic        hRequest,
  output logic [31:0] hAddr,
  output logic        hWrite,
  output logic [31:0] hWData,
  input  logic        hReady
);

  typedef enum logic {stIdle, stBusy} stateE;
  typedef enum logic [1:0] {ownWalk, ownD, ownI} ownerE;

  stateE state;
  ownerE owner;
  ownerE nextOwner;
  logic  ownerReq;
  logic  busy;

  // Walker first, then data, then instruction
  always_comb
  begin
    if (walkRequest)
      nextOwner = ownWalk;
    else if (dRequest)
      nextOwner = ownD;
    else
      nextOwner = ownI;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= stIdle;
      owner <= ownWalk;
    end
    else
    begin
      case (state)
        stIdle:
        begin
          if (walkRequest || dRequest || iRequest)
          begin
            state <= stBusy;
            owner <= nextOwner;
          end
        end
        stBusy:
          if (hReady)
            state <= stIdle;
        default: state <= stIdle;
      endcase
    end
  end

  assign busy = (state == stBusy);

  // Forward the owner's fields, the I side never writes
  always_comb
  begin
    case (owner)
      ownWalk:
      begin
        ownerReq = walkRequest;
        hAddr    = walkAddr;
        hWrite   = walkWrite;
        hWData   = walkWData;
      end
      ownD:
      begin
        ownerReq = dRequest;
        hAddr    = dAddr;
        hWrite   = dWrite;
        hWData   = dWData;
      end
      default:
      begin
        ownerReq = iRequest;
        hAddr    = iAddr;
        hWrite   = 1'b0;
        hWData   = '0;
      end
    endcase
  end

  assign hRequest  = busy && ownerReq;
  assign walkReady = busy && owner == ownWalk && hReady;
  assign dReady    = busy && owner == ownD && hReady;
  assign iReady    = busy && owner == ownI && hReady;

endmodule

// File: busMem.sv
// Wait-stated word memory
`timescale 1ns/10ps

module busMem #(
  parameter int memWords = 256,
  parameter int memWait  = 2
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        hRequest,
  input  logic [31:0] hAddr,
  input  logic        hWrite,
  input  logic [31:0] hWData,
  output logic [31:0] hRData,
  output logic        hReady
);

  localparam int aW   = (memWords > 1) ? $clog2(memWords) : 1;
  localparam int waitW = $clog2(memWait + 2);

  logic [31:0]      mem [memWords];
  logic [aW-1:0]    wordIdx;
  logic             active;
  logic [waitW-1:0] waitCnt;

  // Word address folded onto the array depth
  assign wordIdx = aW'(hAddr[31:2] % memWords);

  // No new transfer in the ready cycle, the request is still up
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      active  <= 1'b0;
      waitCnt <= '0;
      hReady  <= 1'b0;
    end
    else
    begin
      hReady <= 1'b0;
      if (!active)
      begin
        if (hRequest && !hReady)
        begin
          active  <= 1'b1;
          waitCnt <= waitW'(memWait);
        end
      end
      else if (waitCnt != '0)
        waitCnt <= waitCnt - waitW'(1);
      else
      begin
        active <= 1'b0;
        hReady <= 1'b1;
      end
    end
  end

  // Array access on the last wait cycle
  always_ff @(posedge clk)
  begin
    if (active && waitCnt == '0)
    begin
      if (hWrite)
        mem[wordIdx] <= hWData;
      hRData <= mem[wordIdx];
    end
  end

endmodule

// File: cp15Decode.sv
// CP15 access decode
`timescale 1ns/10ps

module cp15Decode (
  input  logic              clk,
  input  logic              rst,
  input  logic              coProcEn,
  input  logic              coProcWrEn,
  input  logic [3:0]        coProcAddr,
  input  logic [3:0]        coProcCRm,
  input  logic [2:0]        coProcOp2,
  input  logic              stallCp,
  output logic              accValid,
  output logic              accWrite,
  output legPkg::cp15RegE   regSel,
  output legPkg::maintOpE   maintOp
);

  legPkg::cp15RegE regSelNext;
  legPkg::maintOpE maintOpNext;

  // Register number and CRm/op2 to enums
  always_comb
  begin
    regSelNext  = legPkg::regNone;
    maintOpNext = legPkg::opNone;
    case (coProcAddr)
      4'd0: regSelNext = legPkg::regId;
      4'd1: regSelNext = legPkg::regControl;
      4'd2: regSelNext = legPkg::regTBase;
      4'd3: regSelNext = legPkg::regDomain;
      4'd5: regSelNext = legPkg::regFsr;
      4'd6: regSelNext = legPkg::regFar;
      4'd7:
      begin
        regSelNext = legPkg::regCacheOp;
        case ({coProcCRm, coProcOp2})
          {4'd5, 3'd0}:  maintOpNext = legPkg::opInvI;
          {4'd6, 3'd0}:  maintOpNext = legPkg::opInvD;
          {4'd7, 3'd0}:  maintOpNext = legPkg::opInvBoth;
          {4'd10, 3'd1}: maintOpNext = legPkg::opCleanD;
          default:       maintOpNext = legPkg::opNone;
        endcase
      end
      4'd8:
      begin
        regSelNext = legPkg::regTlbOp;
        case (coProcCRm)
          4'd5:    maintOpNext = legPkg::opFlushI;
          4'd6:    maintOpNext = legPkg::opFlushD;
          4'd7:    maintOpNext = legPkg::opFlushBoth;
          default: maintOpNext = legPkg::opNone;
        endcase
      end
      default: regSelNext = legPkg::regNone;
    endcase
  end

  // Strobe is dropped while a clean is running
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      accValid <= 1'b0;
      accWrite <= 1'b0;
      regSel   <= legPkg::regNone;
      maintOp  <= legPkg::opNone;
    end
    else
    begin
      accValid <= coProcEn && !stallCp;
      accWrite <= coProcWrEn;
      regSel   <= regSelNext;
      maintOp  <= maintOpNext;
    end
  end

endmodule

// File: cp15Read.sv
// CP15 read-back and cache enables
`timescale 1ns/10ps

module cp15Read #(
  parameter logic [31:0] idValue = 32'h4106_0000
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            accValid,
  input  logic            accWrite,
  input  legPkg::cp15RegE regSel,
  input  logic [31:0]     control,
  input  logic [31:0]     tBase,
  input  logic [31:0]     domain,
  input  logic [31:0]     fsr,
  input  logic [31:0]     far,
  output logic [31:0]     cp15Rd,
  output logic            enI,
  output logic            enD,
  output logic            highVec
);

  logic [31:0] rdNext;

  always_comb
  begin
    case (regSel)
      legPkg::regId:      rdNext = idValue;
      legPkg::regControl: rdNext = control;
      legPkg::regTBase:   rdNext = tBase;
      legPkg::regDomain:  rdNext = domain;
      legPkg::regFsr:     rdNext = fsr;
      legPkg::regFar:     rdNext = far;
      // Maintenance registers read as zero
      default:            rdNext = '0;
    endcase
  end

  // Held until the next read
  always_ff @(posedge clk)
  begin
    if (rst)
      cp15Rd <= '0;
    else if (accValid && !accWrite)
      cp15Rd <= rdNext;
  end

  // Levels seen by the caches and the core
  assign enI     = control[legPkg::ctrlBitEnI];
  assign enD     = control[legPkg::ctrlBitEnD];
  assign highVec = control[legPkg::ctrlBitHighVec];

endmodule

// File: cp15Regs.sv
// CP15 register file and maintenance control
`timescale 1ns/10ps

module cp15Regs #(
  parameter int cleanCycles = 4
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            accValid,
  input  logic            accWrite,
  input  legPkg::cp15RegE regSel,
  input  legPkg::maintOpE maintOp,
  input  logic [31:0]     cpuWriteData,
  input  logic            mmuWriteEn,
  input  logic [31:0]     mmuWriteData,
  output logic [31:0]     control,
  output logic [31:0]     tBase,
  output logic [31:0]     domain,
  output logic [31:0]     fsr,
  output logic [31:0]     far,
  output logic            invI,
  output logic            invD,
  output logic            cleanD,
  output logic            tlbFlushI,
  output logic            tlbFlushD,
  output logic            stallCp
);

  localparam int cntW = $clog2(cleanCycles + 1);

  logic [31:0]     wrData;
  logic            doWrite;
  logic [cntW-1:0] cleanCnt;

  // Core data lags the decoded strobe by one cycle
  always_ff @(posedge clk)
    wrData <= cpuWriteData;

  assign doWrite = accValid && accWrite;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      control <= '0;
      tBase   <= '0;
      domain  <= '0;
      fsr     <= '0;
      far     <= '0;
    end
    else
    begin
      if (doWrite)
      begin
        case (regSel)
          legPkg::regControl: control <= wrData;
          legPkg::regTBase:   tBase   <= {wrData[31:14], 14'b0};
          legPkg::regDomain:  domain  <= wrData;
          legPkg::regFsr:     fsr     <= wrData;
          default:            ;
        endcase
      end
      // Walker has priority on the fault address
      if (mmuWriteEn)
        far <= mmuWriteData;
      else if (doWrite && regSel == legPkg::regFar)
        far <= wrData;
    end
  end

  // One-cycle invalidate and TLB flush strobes
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      invI      <= 1'b0;
      invD      <= 1'b0;
      tlbFlushI <= 1'b0;
      tlbFlushD <= 1'b0;
    end
    else
    begin
      invI      <= doWrite && (maintOp == legPkg::opInvI || maintOp == legPkg::opInvBoth);
      invD      <= doWrite && (maintOp == legPkg::opInvD || maintOp == legPkg::opInvBoth);
      tlbFlushI <= doWrite &&
                   (maintOp == legPkg::opFlushI || maintOp == legPkg::opFlushBoth);
      tlbFlushD <= doWrite &&
                   (maintOp == legPkg::opFlushD || maintOp == legPkg::opFlushBoth);
    end
  end

  // Clean runs for a fixed number of cycles
  always_ff @(posedge clk)
  begin
    if (rst)
      cleanCnt <= '0;
    else if (doWrite && maintOp == legPkg::opCleanD)
      cleanCnt <= cntW'(cleanCycles);
    else if (cleanCnt != '0)
      cleanCnt <= cleanCnt - cntW'(1);
  end

  assign cleanD  = (cleanCnt != '0);
  assign stallCp = (cleanCnt != '0);

endmodule

// File: legPkg.sv
// LEG system control definitions
package legPkg;

  // Target register of a CP15 access
  typedef enum logic [3:0] {
    regId      = 4'd0,
    regControl = 4'd1,
    regTBase   = 4'd2,
    regDomain  = 4'd3,
    regFsr     = 4'd4,
    regFar     = 4'd5,
    regCacheOp = 4'd6,
    regTlbOp   = 4'd7,
    regNone    = 4'd8
  } cp15RegE;

  // Cache and TLB maintenance operations
  typedef enum logic [2:0] {
    opNone      = 3'd0,
    opInvI      = 3'd1,
    opInvD      = 3'd2,
    opInvBoth   = 3'd3,
    opCleanD    = 3'd4,
    opFlushI    = 3'd5,
    opFlushD    = 3'd6,
    opFlushBoth = 3'd7
  } maintOpE;

  // Control register bit positions
  localparam int ctrlBitEnD     = 2;
  localparam int ctrlBitEnI     = 12;
  localparam int ctrlBitHighVec = 13;

endpackage

// File: memSysTb.sv
// Memory system directed testbench
`timescale 1ns/10ps

module memSysTb;

  localparam logic [31:0] idVal      = 32'h4107_b360;
  localparam int          cleanCyc   = 4;
  localparam int          memDepth   = 256;
  localparam int          waitStates = 2;
  // Grant, wait states, array access and ready
  localparam int xferCycles = waitStates + 4;
  localparam int readyLimit = 4 * xferCycles;
  localparam int busOps     = 24;
  localparam int cpOps      = 40;
  localparam int runLimit   = 2 * (16 + busOps * xferCycles + cpOps * (cleanCyc + 3));

  logic        clk;
  logic        rst;
  logic        coProcEn;
  logic        coProcWrEn;
  logic [3:0]  coProcAddr;
  logic [3:0]  coProcCRm;
  logic [2:0]  coProcOp2;
  logic [31:0] cpuWriteData;
  logic        mmuWriteEn;
  logic [31:0] mmuWriteData;
  logic [31:0] cp15Rd;
  logic [31:0] tBase;
  logic [31:0] domain;
  logic        enI;
  logic        enD;
  logic        highVec;
  logic        invI;
  logic        invD;
  logic        cleanD;
  logic        tlbFlushI;
  logic        tlbFlushD;
  logic        stallCp;
  logic        walkRequest;
  logic [31:0] walkAddr;
  logic        walkWrite;
  logic [31:0] walkWData;
  logic        walkReady;
  logic        dRequest;
  logic [31:0] dAddr;
  logic        dWrite;
  logic [31:0] dWData;
  logic        dReady;
  logic        iRequest;
  logic [31:0] iAddr;
  logic        iReady;
  logic [31:0] hRData;
  logic [4:0]  strobeVec;

  integer      seed;
  int          readyOrder[$];
  logic [31:0] model [memDepth];

  memSysTop #(
    .idValue(idVal),
    .cleanCycles(cleanCyc),
    .memWords(memDepth),
    .memWait(waitStates)
  ) dut (
    .clk, .rst, .coProcEn, .coProcWrEn, .coProcAddr, .coProcCRm, .coProcOp2,
    .cpuWriteData, .mmuWriteEn, .mmuWriteData, .cp15Rd, .tBase, .domain,
    .enI, .enD, .highVec, .invI, .invD, .cleanD, .tlbFlushI, .tlbFlushD, .stallCp,
    .walkRequest, .walkAddr, .walkWrite, .walkWData, .walkReady,
    .dRequest, .dAddr, .dWrite, .dWData, .dReady, .iRequest, .iAddr, .iReady, .hRData
  );

  assign strobeVec = {invI, invD, cleanD, tlbFlushI, tlbFlushD};

  always #50 clk = ~clk;

  task automatic abortRun(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (actual !== expected)
      abortRun($sformatf("mismatch %s expected %h actual %h", name, expected, actual));
  endtask

  // Word slot in the memory model
  function automatic int wordIndex(input logic [31:0] addr);
    return int'(addr >> 2) % memDepth;
  endfunction

  // One-cycle core access, returns once the result is visible
  task automatic cpAccess(input logic wr, input logic [3:0] addr, input logic [3:0] crm,
                          input logic [2:0] op2, input logic [31:0] data);
    coProcEn     = 1'b1;
    coProcWrEn   = wr;
    coProcAddr   = addr;
    coProcCRm    = crm;
    coProcOp2    = op2;
    cpuWriteData = data;
    @(negedge clk);
    coProcEn   = 1'b0;
    coProcWrEn = 1'b0;
    @(negedge clk);
  endtask

  task automatic resetState();
    checkValue("reset strobes", 32'h0, {27'b0, strobeVec});
    checkValue("reset stall", 32'h0, {31'b0, stallCp});
    checkValue("reset levels", 32'h0, {29'b0, highVec, enI, enD});
    checkValue("reset readies", 32'h0, {29'b0, walkReady, dReady, iReady});
    checkValue("reset tBase", 32'h0, tBase);
    checkValue("reset domain", 32'h0, domain);
    cpAccess(1'b0, 4'd1, 4'd0, 3'd0, 32'h0);
    checkValue("reset control", 32'h0, cp15Rd);
  endtask

  task automatic regReadBack();
    logic [31:0] ctrlVal;
    logic [31:0] baseVal;
    logic [31:0] domVal;
    logic [31:0] fsrVal;
    ctrlVal = $random(seed);
    baseVal = $random(seed);
    domVal  = $random(seed);
    fsrVal  = $random(seed);
    cpAccess(1'b1, 4'd1, 4'd0, 3'd0, ctrlVal);
    cpAccess(1'b1, 4'd2, 4'd0, 3'd0, baseVal);
    checkValue("tBase level", baseVal & 32'hffff_c000, tBase);
    cpAccess(1'b1, 4'd3, 4'd0, 3'd0, domVal);
    checkValue("domain level", domVal, domain);
    cpAccess(1'b1, 4'd5, 4'd0, 3'd0, fsrVal);
    cpAccess(1'b0, 4'd1, 4'd0, 3'd0, 32'h0);
    checkValue("control read", ctrlVal, cp15Rd);
    cpAccess(1'b0, 4'd2, 4'd0, 3'd0, 32'h0);
    checkValue("tBase read", baseVal & 32'hffff_c000, cp15Rd);
    cpAccess(1'b0, 4'd3, 4'd0, 3'd0, 32'h0);
    checkValue("domain read", domVal, cp15Rd);
    cpAccess(1'b0, 4'd5, 4'd0, 3'd0, 32'h0);
    checkValue("fsr read", fsrVal, cp15Rd);
    // ID is read-only
    cpAccess(1'b1, 4'd0, 4'd0, 3'd0, ~idVal);
    cpAccess(1'b0, 4'd0, 4'd0, 3'd0, 32'h0);
    checkValue("id read", idVal, cp15Rd);
    cpAccess(1'b0, 4'd4, 4'd0, 3'd0, 32'h0);
    checkValue("unmapped read", 32'h0, cp15Rd);
  endtask

  task automatic controlLevels();
    int          bitPos[3];
    logic [31:0] setMask;
    int          b;
    bitPos  = '{legPkg::ctrlBitEnD, legPkg::ctrlBitEnI, legPkg::ctrlBitHighVec};
    setMask = 32'h0;
    // One bit at a time, levels ordered {highVec, enI, enD}
    for (b = 0; b < 3; b++)
    begin
      cpAccess(1'b1, 4'd1, 4'd0, 3'd0, 32'h1 << bitPos[b]);
      checkValue($sformatf("level bit %0d", bitPos[b]), 32'h1 << b,
                 {29'b0, highVec, enI, enD});
      setMask = setMask | (32'h1 << bitPos[b]);
    end
    cpAccess(1'b1, 4'd1, 4'd0, 3'd0, setMask);
    checkValue("levels all set", 32'h7, {29'b0, highVec, enI, enD});
    cpAccess(1'b1, 4'd1, 4'd0, 3'd0, ~setMask);
    checkValue("levels cleared", 32'h0, {29'b0, highVec, enI, enD});
  endtask

  // Strobe order {invI, invD, cleanD, tlbFlushI, tlbFlushD}
  task automatic strobeCase(input string name, input logic [3:0] addr, input logic [3:0] crm,
                            input logic [2:0] op2, input logic [4:0] expected);
    cpAccess(1'b1, addr, crm, op2, 32'h0);
    checkValue(name, {27'b0, expected}, {27'b0, strobeVec});
    checkValue({name, " stall"}, 32'h0, {31'b0, stallCp});
    @(negedge clk);
    checkValue({name, " after"}, 32'h0, {27'b0, strobeVec});
  endtask

  task automatic maintStrobes();
    int cycles;
    strobeCase("inv I", 4'd7, 4'd5, 3'd0, 5'b10000);
    strobeCase("inv D", 4'd7, 4'd6, 3'd0, 5'b01000);
    strobeCase("inv both", 4'd7, 4'd7, 3'd0, 5'b11000);
    strobeCase("flush I TLB", 4'd8, 4'd5, 3'd0, 5'b00010);
    strobeCase("flush D TLB", 4'd8, 4'd6, 3'd0, 5'b00001);
    strobeCase("flush both TLB", 4'd8, 4'd7, 3'd0, 5'b00011);
    strobeCase("reg7 unknown op", 4'd7, 4'd5, 3'd1, 5'b00000);
    strobeCase("reg8 unknown op", 4'd8, 4'd9, 3'd0, 5'b00000);
    cpAccess(1'b1, 4'd3, 4'd0, 3'd0, ~idVal);
    cpAccess(1'b0, 4'd3, 4'd0, 3'd0, 32'h0);
    checkValue("domain before clean", ~idVal, cp15Rd);
    cpAccess(1'b1, 4'd7, 4'd10, 3'd1, 32'h0);
    checkValue("clean strobes", 32'h4, {27'b0, strobeVec});
    // ID read lands while stalled
    coProcEn   = 1'b1;
    coProcWrEn = 1'b0;
    coProcAddr = 4'd0;
    cycles     = 0;
    while (cleanD && cycles <= cleanCyc)
    begin
      checkValue("clean stall", 32'h1, {31'b0, stallCp});
      cycles++;
      @(negedge clk);
      coProcEn = 1'b0;
    end
    checkValue("clean length", 32'(cleanCyc), 32'(cycles));
    checkValue("stall released", 32'h0, {31'b0, stallCp});
    checkValue("stalled read", ~idVal, cp15Rd);
  endtask

  task automatic farPriority();
    logic [31:0] mmuVal;
    logic [31:0] coreVal;
    mmuVal  = $random(seed);
    coreVal = $random(seed);
    mmuWriteEn   = 1'b1;
    mmuWriteData = mmuVal;
    @(negedge clk);
    mmuWriteEn = 1'b0;
    cpAccess(1'b0, 4'd6, 4'd0, 3'd0, 32'h0);
    checkValue("far mmu alone", mmuVal, cp15Rd);
    cpAccess(1'b1, 4'd6, 4'd0, 3'd0, coreVal);
    cpAccess(1'b0, 4'd6, 4'd0, 3'd0, 32'h0);
    checkValue("far core alone", coreVal, cp15Rd);
    // Core write executes in the cycle of the MMU write
    coProcEn     = 1'b1;
    coProcWrEn   = 1'b1;
    coProcAddr   = 4'd6;
    cpuWriteData = ~coreVal;
    @(negedge clk);
    coProcEn     = 1'b0;
    coProcWrEn   = 1'b0;
    mmuWriteEn   = 1'b1;
    mmuWriteData = ~mmuVal;
    @(negedge clk);
    mmuWriteEn = 1'b0;
    cpAccess(1'b0, 4'd6, 4'd0, 3'd0, 32'h0);
    checkValue("far mmu wins", ~mmuVal, cp15Rd);
  endtask

  // Master 0 walker, 1 data cache, 2 instruction cache
  task automatic busTransfer(input int master, input logic wr, input logic [31:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
    int   waited;
    logic ready;
    waited = 0;
    ready  = 1'b0;
    if (master == 0)
    begin
      walkAddr    = addr;
      walkWrite   = wr;
      walkWData   = wdata;
      walkRequest = 1'b1;
    end
    else if (master == 1)
    begin
      dAddr    = addr;
      dWrite   = wr;
      dWData   = wdata;
      dRequest = 1'b1;
    end
    else
    begin
      iAddr    = addr;
      iRequest = 1'b1;
    end
    while (!ready)
    begin
      @(negedge clk);
      waited++;
      ready = (master == 0) ? walkReady : ((master == 1) ? dReady : iReady);
      if (!ready && waited > readyLimit)
        abortRun($sformatf("no ready for master %0d after %0d cycles", master, waited));
    end
    rdata = hRData;
    readyOrder.push_back(master);
    case (master)
      0: walkRequest = 1'b0;
      1: dRequest = 1'b0;
      default: iRequest = 1'b0;
    endcase
  endtask

  task automatic busWriteRead();
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] rd;
    int          n;
    for (n = 0; n < 6; n++)
    begin
      addr = 32'h0000_0200 + 32'(n * 12);
      data = $random(seed);
      busTransfer(n % 2, 1'b1, addr, data, rd);
      model[wordIndex(addr)] = data;
    end
    for (n = 0; n < 6; n++)
    begin
      addr = 32'h0000_0200 + 32'(n * 12);
      busTransfer(n % 3, 1'b0, addr, 32'h0, rd);
      checkValue($sformatf("bus read master %0d at %h", n % 3, addr),
                 model[wordIndex(addr)], rd);
    end
    // Beyond the depth the address folds back
    addr = 32'h0000_0200 + 32'(memDepth * 4);
    busTransfer(2, 1'b0, addr, 32'h0, rd);
    checkValue("bus folded read", model[wordIndex(addr)], rd);
  endtask

  task automatic busContention();
    logic [31:0] data;
    logic [31:0] rdW;
    logic [31:0] rdD;
    logic [31:0] rdI;
    int          n;
    for (n = 0; n < 3; n++)
    begin
      data = $random(seed);
      busTransfer(1, 1'b1, 32'h0000_0300 + 32'(n * 4), data, rdD);
      model[wordIndex(32'h0000_0300 + 32'(n * 4))] = data;
    end
    readyOrder.delete();
    fork
      busTransfer(2, 1'b0, 32'h0000_0308, 32'h0, rdI);
      busTransfer(1, 1'b0, 32'h0000_0304, 32'h0, rdD);
      busTransfer(0, 1'b0, 32'h0000_0300, 32'h0, rdW);
    join
    checkValue("contention count", 32'd3, 32'(readyOrder.size()));
    for (n = 0; n < 3; n++)
      checkValue($sformatf("ready order slot %0d", n), 32'(n), 32'(readyOrder[n]));
    checkValue("contention walker data", model[wordIndex(32'h0000_0300)], rdW);
    checkValue("contention data data", model[wordIndex(32'h0000_0304)], rdD);
    checkValue("contention instr data", model[wordIndex(32'h0000_0308)], rdI);
  endtask

  initial
  begin
    repeat (runLimit) @(posedge clk);
    abortRun($sformatf("watchdog expired after %0d cycles", runLimit));
  end

  initial
  begin
    seed         = 32'hb94f;
    clk          = 1'b0;
    rst          = 1'b1;
    coProcEn     = 1'b0;
    coProcWrEn   = 1'b0;
    coProcAddr   = 4'd0;
    coProcCRm    = 4'd0;
    coProcOp2    = 3'd0;
    cpuWriteData = 32'h0;
    mmuWriteEn   = 1'b0;
    mmuWriteData = 32'h0;
    walkRequest  = 1'b0;
    walkAddr     = 32'h0;
    walkWrite    = 1'b0;
    walkWData    = 32'h0;
    dRequest     = 1'b0;
    dAddr        = 32'h0;
    dWrite       = 1'b0;
    dWData       = 32'h0;
    iRequest     = 1'b0;
    iAddr        = 32'h0;
    repeat (16) @(negedge clk);
    rst = 1'b0;
    resetState();
    regReadBack();
    controlLevels();
    maintStrobes();
    farPriority();
    busWriteRead();
    busContention();
    $display(">>> PASS");
    $finish;
  end

endmodule

// File: memSysTop.sv
// Coprocessor and memory bus top level
`timescale 1ns/10ps

module memSysTop #(
  parameter logic [31:0] idValue     = 32'h4106_0000,
  parameter int          cleanCycles = 4,
  parameter int          memWords    = 256,
  parameter int          memWait     = 2
) (
  input  logic        clk,
  input  logic        rst,
  // Core memory stage
  input  logic        coProcEn,
  input  logic        coProcWrEn,
  input  logic [3:0]  coProcAddr,
  input  logic [3:0]  coProcCRm,
  input  logic [2:0]  coProcOp2,
  input  logic [31:0] cpuWriteData,
  input  logic        mmuWriteEn,
  input  logic [31:0] mmuWriteData,
  output logic [31:0] cp15Rd,
  output logic [31:0] tBase,
  output logic [31:0] domain,
  output logic        enI,
  output logic        enD,
  output logic        highVec,
  output logic        invI,
  output logic        invD,
  output logic        cleanD,
  output logic        tlbFlushI,
  output logic        tlbFlushD,
  output logic        stallCp,
  // Bus masters
  input  logic        walkRequest,
  input  logic [31:0] walkAddr,
  input  logic        walkWrite,
  input  logic [31:0] walkWData,
  output logic        walkReady,
  input  logic        dRequest,
  input  logic [31:0] dAddr,
  input  logic        dWrite,
  input  logic [31:0] dWData,
  output logic        dReady,
  input  logic        iRequest,
  input  logic [31:0] iAddr,
  output logic        iReady,
  output logic [31:0] hRData
);

  logic            accValid;
  logic            accWrite;
  legPkg::cp15RegE regSel;
  legPkg::maintOpE maintOp;
  logic [31:0]     control;
  logic [31:0]     fsr;
  logic [31:0]     far;
  logic            hRequest;
  logic [31:0]     hAddr;
  logic            hWrite;
  logic [31:0]     hWData;
  logic            hReady;

  cp15Decode decode (
    .clk, .rst, .coProcEn, .coProcWrEn, .coProcAddr, .coProcCRm, .coProcOp2,
    .stallCp, .accValid, .accWrite, .regSel, .maintOp
  );

  cp15Regs #(.cleanCycles(cleanCycles)) regs (
    .clk, .rst, .accValid, .accWrite, .regSel, .maintOp, .cpuWriteData,
    .mmuWriteEn, .mmuWriteData, .control, .tBase, .domain, .fsr, .far,
    .invI, .invD, .cleanD, .tlbFlushI, .tlbFlushD, .stallCp
  );

  cp15Read #(.idValue(idValue)) rdStage (
    .clk, .rst, .accValid, .accWrite, .regSel, .control, .tBase, .domain,
    .fsr, .far, .cp15Rd, .enI, .enD, .highVec
  );

  busArbiter arb (
    .clk, .rst, .walkRequest, .walkAddr, .walkWrite, .walkWData,
    .dRequest, .dAddr, .dWrite, .dWData, .iRequest, .iAddr,
    .walkReady, .dReady, .iReady,
    .hRequest, .hAddr, .hWrite, .hWData, .hReady
  );

  busMem #(.memWords(memWords), .memWait(memWait)) mem (
    .clk, .rst, .hRequest, .hAddr, .hWrite, .hWData, .hRData, .hReady
  );

endmodule

// File: src.f
legPkg.sv
cp15Decode.sv
cp15Regs.sv
cp15Read.sv
busArbiter.sv
busMem.sv
memSysTop.sv
memSysTb.sv
